// ==== Bender.yml ====
package:
  name: branch_predictor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/bpu_pkg.sv
      - rtl/branch_target_buffer.sv
      - rtl/predictor_unit.sv
      - rtl/next_pc_select.sv
      - rtl/branch_predictor.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_checker.sv
      - test/tb_branch_predictor.sv

// ==== branch_predictor.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/bpu_pkg.sv
rtl/branch_target_buffer.sv
rtl/predictor_unit.sv
rtl/next_pc_select.sv
rtl/branch_predictor.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_branch_predictor.sv

// ==== rtl/bpu_pkg.sv ====
// -------------------------------------------------------------------------
// Types exchanged between the branch prediction stages and execute
// Field widths follow the depths in bpu_settings.svh, which must be
// powers of two; the low address bits below the instruction step are unused
// -------------------------------------------------------------------------

`include "bpu_settings.svh"

package bpu_pkg;

    // ---------------------------------------------------------------------
    // Address slicing
    // ---------------------------------------------------------------------

    // Program counter bits that are always zero for aligned instructions
    localparam int PC_OFFSET_W = $clog2(`INSTR_BYTES);

    // Index and tag split of the program counter for the target buffer
    localparam int BTB_INDEX_W = $clog2(`BRANCH_TARGET_BUFFER_DEPTH);
    localparam int BTB_TAG_W   = core_pkg::XLEN - BTB_INDEX_W - PC_OFFSET_W;

    // The counter table takes its index from the same low pc bits
    localparam int PRED_INDEX_W = $clog2(`BRANCH_PREDICTOR_DEPTH);

    // Distance to the sequential successor of an instruction
    localparam core_pkg::data_word_t INSTR_STEP = `INSTR_BYTES;

    // ---------------------------------------------------------------------
    // Two-bit saturating counter encodings
    // ---------------------------------------------------------------------

    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } sat_counter_t;

    // ---------------------------------------------------------------------
    // Stage payloads
    // ---------------------------------------------------------------------

    // One target buffer line
    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        core_pkg::data_word_t target;
        logic                 is_jump;
    } btb_entry_t;

    // Result of the target buffer lookup that stage 1 hands to stage 2
    typedef struct packed {
        core_pkg::data_word_t pc;
        logic                 hit;
        core_pkg::data_word_t target;
        logic                 is_jump;
    } btb_lookup_t;

    // Final prediction for one program counter
    typedef struct packed {
        core_pkg::data_word_t pc;
        logic                 hit;
        logic                 taken;
        core_pkg::data_word_t target;
    } prediction_t;

    // Outcome of one executed control instruction
    // It echoes the prediction fetch made, so no history is kept here
    typedef struct packed {
        logic                 executed;
        core_pkg::data_word_t pc;
        core_pkg::data_word_t target;
        logic                 taken;
        logic                 is_branch;
        logic                 is_jump;
        logic                 pred_taken;
        core_pkg::data_word_t pred_target;
    } resolve_t;

endpackage : bpu_pkg

// ==== rtl/bpu_settings.svh ====
// -------------------------------------------------------------------------
// Sizing of the branch prediction tables
// Both depths must be powers of two
// -------------------------------------------------------------------------

`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

// Number of lines in the direct-mapped branch target buffer
`define BRANCH_TARGET_BUFFER_DEPTH 16

// Number of two-bit counters in the direction table
`define BRANCH_PREDICTOR_DEPTH 32

// Byte distance between consecutive instructions
`define INSTR_BYTES 4

`endif

// ==== rtl/branch_predictor.sv ====
// -------------------------------------------------------------------------
// Fetch-side branch prediction unit built from three pipeline stages
// prediction_o refers to the pc presented two cycles earlier; next_pc_o is
// combinational from it and from a pending misprediction redirect
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module branch_predictor (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  core_pkg::data_word_t program_counter_i,
    input  bpu_pkg::resolve_t    resolve_i,
    output bpu_pkg::prediction_t prediction_o,
    output core_pkg::data_word_t next_pc_o,
    output logic                 mispredicted_o
);

    import bpu_pkg::*;

    // Stage 1 result, registered inside the target buffer
    btb_lookup_t btb_lookup;

    // Stage 2 result, also visible at the top
    prediction_t prediction;

    // ---------------------------------------------------------------------
    // Stage 1 target lookup
    // ---------------------------------------------------------------------

    branch_target_buffer btb_unit (
        .clk_i             ( clk_i             ),
        .reset_i           ( reset_i           ),
        .program_counter_i ( program_counter_i ),
        .resolve_i         ( resolve_i         ),
        .lookup_o          ( btb_lookup        )
    );

    // ---------------------------------------------------------------------
    // Stage 2 direction
    // ---------------------------------------------------------------------

    predictor_unit direction_unit (
        .clk_i        ( clk_i      ),
        .reset_i      ( reset_i    ),
        .lookup_i     ( btb_lookup ),
        .resolve_i    ( resolve_i  ),
        .prediction_o ( prediction )
    );

    // ---------------------------------------------------------------------
    // Stage 3 next address and redirect
    // ---------------------------------------------------------------------

    next_pc_select next_pc_unit (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .prediction_i   ( prediction     ),
        .resolve_i      ( resolve_i      ),
        .next_pc_o      ( next_pc_o      ),
        .mispredicted_o ( mispredicted_o )
    );

    assign prediction_o = prediction;

endmodule : branch_predictor

// ==== rtl/branch_target_buffer.sv ====
// -------------------------------------------------------------------------
// Stage 1 is a direct-mapped branch target buffer with a registered lookup
// Only jumps and taken branches allocate; a resolve and a lookup in the
// same cycle see the table contents from before the write
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "bpu_settings.svh"

module branch_target_buffer (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  core_pkg::data_word_t program_counter_i,
    input  bpu_pkg::resolve_t    resolve_i,
    output bpu_pkg::btb_lookup_t lookup_o
);

    import core_pkg::*;
    import bpu_pkg::*;

    // ---------------------------------------------------------------------
    // Storage
    // ---------------------------------------------------------------------

    btb_entry_t btb_table [`BRANCH_TARGET_BUFFER_DEPTH];

    // Read side
    logic [BTB_INDEX_W-1:0] lookup_index;
    logic [BTB_TAG_W-1:0]   lookup_tag;
    btb_entry_t             lookup_entry;
    logic                   lookup_hit;

    // Write side
    logic [BTB_INDEX_W-1:0] write_index;
    logic [BTB_TAG_W-1:0]   write_tag;
    logic                   write_en;

    // Registered lookup result
    logic       hit_q;
    logic       is_jump_q;
    data_word_t pc_q;
    data_word_t target_q;

    // ---------------------------------------------------------------------
    // Lookup
    // ---------------------------------------------------------------------

    // The index sits right above the always-zero offset bits
    assign lookup_index = program_counter_i[PC_OFFSET_W +: BTB_INDEX_W];
    // Everything above the index is kept as tag
    assign lookup_tag   = program_counter_i[XLEN-1 -: BTB_TAG_W];
    assign lookup_entry = btb_table[lookup_index];

    // A line from another pc with the same index must not hit
    assign lookup_hit = lookup_entry.valid && (lookup_entry.tag == lookup_tag);

    // ---------------------------------------------------------------------
    // Allocation
    // ---------------------------------------------------------------------

    assign write_index = resolve_i.pc[PC_OFFSET_W +: BTB_INDEX_W];
    assign write_tag   = resolve_i.pc[XLEN-1 -: BTB_TAG_W];

    // Not-taken branches never allocate, so a miss keeps meaning not taken
    assign write_en = resolve_i.executed &&
                      (resolve_i.is_jump || (resolve_i.is_branch && resolve_i.taken));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Reset invalidates every line
            for (int i = 0; i < `BRANCH_TARGET_BUFFER_DEPTH; i++) begin
                btb_table[i].valid <= 1'b0;
            end
        end else if (write_en) begin
            // A line with the same index is simply overwritten
            btb_table[write_index].valid   <= 1'b1;
            btb_table[write_index].tag     <= write_tag;
            btb_table[write_index].target  <= resolve_i.target;
            btb_table[write_index].is_jump <= resolve_i.is_jump;
        end
    end

    // ---------------------------------------------------------------------
    // Output register
    // ---------------------------------------------------------------------

    // Hit and jump flag of the registered lookup, both steering stage 2
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hit_q     <= 1'b0;
            is_jump_q <= 1'b0;
        end else begin
            hit_q     <= lookup_hit;
            is_jump_q <= lookup_hit && lookup_entry.is_jump;
        end
    end

    // Pc and stored target of the registered lookup
    always_ff @(posedge clk_i) begin
        pc_q     <= program_counter_i;
        target_q <= lookup_entry.target;
    end

    assign lookup_o = '{
        pc:      pc_q,
        hit:     hit_q,
        target:  target_q,
        is_jump: is_jump_q
    };

endmodule : branch_target_buffer

// ==== rtl/core_pkg.sv ====
// -------------------------------------------------------------------------
// Word types of a 32-bit in-order core that fetch, decode and execute share
// Program counters and branch targets are full byte addresses in this type
// -------------------------------------------------------------------------

package core_pkg;

    // ---------------------------------------------------------------------
    // Datapath width
    // ---------------------------------------------------------------------

    // Width of every architectural register and of the program counter
    localparam int XLEN = 32;

    // ---------------------------------------------------------------------
    // Word types
    // ---------------------------------------------------------------------

    // One machine word
    // Used for program counters, branch targets and operand values alike
    typedef logic [XLEN-1:0] data_word_t;

endpackage : core_pkg

// ==== rtl/next_pc_select.sv ====
// -------------------------------------------------------------------------
// Stage 3 forms the next fetch address and checks for mispredictions
// The misprediction pulse and its redirect follow the resolve by one cycle
// and take priority over the predicted address in that cycle
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module next_pc_select (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  bpu_pkg::prediction_t prediction_i,
    input  bpu_pkg::resolve_t    resolve_i,
    output core_pkg::data_word_t next_pc_o,
    output logic                 mispredicted_o
);

    import core_pkg::*;
    import bpu_pkg::*;

    logic       direction_wrong;
    logic       target_wrong;
    logic       mispredict;
    data_word_t redirect_pc;
    data_word_t predicted_pc;

    logic       mispredicted_q;
    data_word_t redirect_q;

    // ---------------------------------------------------------------------
    // Misprediction detection
    // ---------------------------------------------------------------------

    // Fetch went the wrong way
    assign direction_wrong = resolve_i.pred_taken != resolve_i.taken;

    // Direction was right but fetch jumped to a stale or aliased target
    assign target_wrong = resolve_i.pred_taken && resolve_i.taken &&
                          (resolve_i.pred_target != resolve_i.target);

    assign mispredict = resolve_i.executed && (direction_wrong || target_wrong);

    // Where fetch must restart after a misprediction
    assign redirect_pc = resolve_i.taken ? resolve_i.target
                                         : resolve_i.pc + INSTR_STEP;

    // The flag is a single pulse, since executed is a one-cycle strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mispredicted_q <= 1'b0;
        end else begin
            mispredicted_q <= mispredict;
        end
    end

    // Restart address captured in the same cycle as the flag
    always_ff @(posedge clk_i) begin
        redirect_q <= redirect_pc;
    end

    // ---------------------------------------------------------------------
    // Next fetch address
    // ---------------------------------------------------------------------

    // Predicted target when taken, otherwise the sequential successor
    assign predicted_pc = prediction_i.taken ? prediction_i.target
                                             : prediction_i.pc + INSTR_STEP;

    // A pending redirect wins over whatever the predictor offers
    assign next_pc_o      = mispredicted_q ? redirect_q : predicted_pc;
    assign mispredicted_o = mispredicted_q;

endmodule : next_pc_select

// ==== rtl/predictor_unit.sv ====
// -------------------------------------------------------------------------
// Stage 2 is a table of two-bit saturating counters indexed by pc
// Counters only move on resolved branches; jumps are taken on any hit
// -------------------------------------------------------------------------

`timescale 1ns/1ps

`include "bpu_settings.svh"

module predictor_unit (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  bpu_pkg::btb_lookup_t lookup_i,
    input  bpu_pkg::resolve_t    resolve_i,
    output bpu_pkg::prediction_t prediction_o
);

    import core_pkg::*;
    import bpu_pkg::*;

    sat_counter_t counter_table [`BRANCH_PREDICTOR_DEPTH];

    logic [PRED_INDEX_W-1:0] read_index;
    logic [PRED_INDEX_W-1:0] update_index;
    sat_counter_t            read_counter;
    sat_counter_t            update_counter;
    sat_counter_t            next_counter;
    logic                    update_en;
    logic                    predict_taken;

    logic       hit_q;
    logic       taken_q;
    data_word_t pc_q;
    data_word_t target_q;

    // ---------------------------------------------------------------------
    // Counter read and direction decision
    // ---------------------------------------------------------------------

    // Indexing by pc gives every branch in range its own counter
    assign read_index   = lookup_i.pc[PC_OFFSET_W +: PRED_INDEX_W];
    assign read_counter = counter_table[read_index];

    // A miss never predicts taken, whatever the counter says
    assign predict_taken = lookup_i.hit &&
                           (lookup_i.is_jump || (read_counter >= WEAK_TAKEN));

    // ---------------------------------------------------------------------
    // Counter update
    // ---------------------------------------------------------------------

    assign update_index   = resolve_i.pc[PC_OFFSET_W +: PRED_INDEX_W];
    assign update_counter = counter_table[update_index];
    assign update_en      = resolve_i.executed && resolve_i.is_branch;

    // Step one state toward the outcome and stick at either end
    always_comb begin
        next_counter = update_counter;
        if (resolve_i.taken && (update_counter != STRONG_TAKEN)) begin
            next_counter = sat_counter_t'(update_counter + 2'd1);
        end else if (!resolve_i.taken && (update_counter != STRONG_NOT_TAKEN)) begin
            next_counter = sat_counter_t'(update_counter - 2'd1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `BRANCH_PREDICTOR_DEPTH; i++) begin
                counter_table[i] <= WEAK_NOT_TAKEN;
            end
        end else if (update_en) begin
            counter_table[update_index] <= next_counter;
        end
    end

    // ---------------------------------------------------------------------
    // Prediction register
    // ---------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hit_q   <= 1'b0;
            taken_q <= 1'b0;
        end else begin
            hit_q   <= lookup_i.hit;
            taken_q <= predict_taken;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q     <= lookup_i.pc;
        target_q <= lookup_i.target;
    end

    assign prediction_o = '{
        pc:     pc_q,
        hit:    hit_q,
        taken:  taken_q,
        target: target_q
    };

endmodule : predictor_unit

// ==== test/bpu_stimulus.txt ====
// lookup:  0 pc exp_hit exp_taken exp_target exp_next_pc 0
// resolve: 1 pc target flags(taken branch jump pred_taken) pred_target exp_mispredict exp_redirect
// Cold tables miss everywhere
0 00000100 0 0 00000000 00000104 0
0 00002000 0 0 00000000 00002004 0
// Taken branch allocates and moves its counter to weakly taken
1 00000100 00000180 1100 00000000 1 00000180
0 00000100 1 1 00000180 00000180 0
1 00000100 00000180 1101 00000180 0 00000000
// Jump stays taken even after an aliasing branch pulls the counter to zero
1 00000204 00000300 1010 00000000 1 00000300
0 00000204 1 1 00000300 00000300 0
1 00000284 00000000 0100 00000000 0 00000000
0 00000204 1 1 00000300 00000300 0
// Branch trained down to not taken while its line still hits
1 00000108 00000140 1100 00000000 1 00000140
0 00000108 1 1 00000140 00000140 0
1 00000108 00000140 0101 00000140 1 0000010c
1 00000108 00000140 0100 00000000 0 00000000
0 00000108 1 0 00000140 0000010c 0
// Direction right but target wrong, then a new target replaces the old one
1 00000100 00000180 1101 000001c0 1 00000180
1 00000100 000001a0 1101 00000180 1 000001a0
0 00000100 1 1 000001a0 000001a0 0
// Same index, different tag, the second allocation evicts the first
0 00000140 0 0 00000000 00000144 0
1 00000140 00000400 1010 00000000 1 00000400
0 00000140 1 1 00000400 00000400 0
0 00000100 0 0 00000000 00000104 0
f 0 0 0 0 0 0

// ==== test/tb_branch_predictor.sv ====
// --------------------------------------------------------------------------
// Testbench top that replays lookup and resolve records from the stimulus file
// Each record takes three cycles so lookups never meet table writes
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_branch_predictor;

    import core_pkg::*;
    import bpu_pkg::*;

    localparam int REC_WORDS   = 7;
    localparam int MAX_RECORDS = 64;
    localparam int RESOLVE     = 1;
    localparam int END_MARK    = 'hf;

    logic        clk;
    logic        reset;
    data_word_t  program_counter;
    resolve_t    resolve;
    prediction_t prediction;
    data_word_t  next_pc;
    logic        mispredicted;

    // Expected record handed to the checker
    logic        exp_valid;
    logic        exp_is_resolve;
    logic        exp_mispredicted;
    prediction_t exp_prediction;
    data_word_t  exp_next_pc;

    int pending;
    int value_errors;
    int other_errors;
    int file_errors = 0;
    int record_count = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;

    logic [31:0] stim_mem [REC_WORDS*MAX_RECORDS];

    tb_clock_gen clock_gen_i (.clk_o(clk), .reset_o(reset));

    branch_predictor dut_i (
        .clk_i             ( clk             ),
        .reset_i           ( reset           ),
        .program_counter_i ( program_counter ),
        .resolve_i         ( resolve         ),
        .prediction_o      ( prediction      ),
        .next_pc_o         ( next_pc         ),
        .mispredicted_o    ( mispredicted    )
    );

    tb_checker checker_i (
        .clk_i              ( clk              ),
        .reset_i            ( reset            ),
        .prediction_i       ( prediction       ),
        .next_pc_i          ( next_pc          ),
        .mispredicted_i     ( mispredicted     ),
        .exp_valid_i        ( exp_valid        ),
        .exp_is_resolve_i   ( exp_is_resolve   ),
        .exp_prediction_i   ( exp_prediction   ),
        .exp_next_pc_i      ( exp_next_pc      ),
        .exp_mispredicted_i ( exp_mispredicted ),
        .pending_o          ( pending          ),
        .value_errors_o     ( value_errors     ),
        .other_errors_o     ( other_errors     )
    );

    // Walk the records up to the end marker and reject anything else
    task automatic count_records();
        logic [31:0] kind;
        logic        done;
        done = 1'b0;
        while (!done) begin
            kind = stim_mem[record_count*REC_WORDS];
            if (kind == END_MARK) begin
                done = 1'b1;
            end else if ($isunknown(kind) || kind > RESOLVE
                         || record_count == MAX_RECORDS - 1) begin
                $display("stimulus file ends after %0d records without its end marker",
                         record_count);
                file_errors++;
                done = 1'b1;
            end else begin
                record_count++;
            end
        end
    endtask

    task automatic apply_record(input int idx);
        logic [31:0] w [REC_WORDS];
        for (int i = 0; i < REC_WORDS; i++) begin
            w[i] = stim_mem[idx*REC_WORDS + i];
        end
        @(posedge clk);
        if (w[0] == RESOLVE) begin
            // Flag word holds one hex digit each for taken, branch, jump, predicted
            resolve <= '{executed: 1'b1, pc: w[1], target: w[2], taken: w[3][12],
                         is_branch: w[3][8], is_jump: w[3][4], pred_taken: w[3][0],
                         pred_target: w[4]};
            exp_is_resolve   <= 1'b1;
            exp_prediction   <= '0;
            exp_mispredicted <= w[5][0];
            exp_next_pc      <= w[6];
        end else begin
            program_counter  <= w[1];
            exp_is_resolve   <= 1'b0;
            exp_prediction   <= '{pc: w[1], hit: w[2][0], taken: w[3][0], target: w[4]};
            exp_mispredicted <= 1'b0;
            exp_next_pc      <= w[5];
        end
        exp_valid <= 1'b1;
        @(posedge clk);
        // Execute leaves the last outcome on the bus and only drops the strobe
        resolve.executed <= 1'b0;
        program_counter  <= '0;
        exp_valid        <= 1'b0;
        @(posedge clk);
    endtask

    // Hung run guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        program_counter  = '0;
        resolve          = '0;
        exp_valid        = 1'b0;
        exp_is_resolve   = 1'b0;
        exp_mispredicted = 1'b0;
        exp_prediction   = '0;
        exp_next_pc      = '0;
        $readmemh("test/bpu_stimulus.txt", stim_mem);
        count_records();
        cycle_limit = 4 * record_count + 20;
        @(negedge reset);
        for (int i = 0; i < record_count; i++) begin
            apply_record(i);
        end
        while (pending != 0) begin
            @(posedge clk);
        end
        $display("error counts: value %0d, other %0d, stimulus file %0d",
                 value_errors, other_errors, file_errors);
        if (value_errors + other_errors + file_errors == 0 && record_count > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_branch_predictor

// ==== test/tb_checker.sv ====
// --------------------------------------------------------------------------
// Compares DUT outputs with queued expected records at the falling edge
// A lookup falls due two cycles after it is seen, a resolve one cycle after
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_checker (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  bpu_pkg::prediction_t prediction_i,
    input  core_pkg::data_word_t next_pc_i,
    input  logic                 mispredicted_i,
    input  logic                 exp_valid_i,
    input  logic                 exp_is_resolve_i,
    input  bpu_pkg::prediction_t exp_prediction_i,
    input  core_pkg::data_word_t exp_next_pc_i,
    input  logic                 exp_mispredicted_i,
    output int                   pending_o,
    output int                   value_errors_o,
    output int                   other_errors_o
);

    import core_pkg::*;
    import bpu_pkg::*;

    // One expected record and the cycle in which it falls due
    typedef struct packed {
        logic [31:0] due;
        logic        is_resolve;
        prediction_t prediction;
        data_word_t  next_pc;
        logic        mispredicted;
    } expect_t;

    expect_t     expect_q [$];
    expect_t     entry;
    logic [31:0] cycle;
    logic        resolve_due;

    task compare_word(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h in cycle %0d", name, got, want, cycle);
            value_errors_o++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Sampling at the falling edge where all DUT outputs have settled
    // ----------------------------------------------------------------------

    always @(negedge clk_i) begin
        if (reset_i) begin
            cycle          = '0;
            value_errors_o = 0;
            other_errors_o = 0;
            expect_q.delete();
        end else begin
            cycle       = cycle + 1;
            resolve_due = 1'b0;
            if (exp_valid_i) begin
                entry.due          = cycle + (exp_is_resolve_i ? 32'd1 : 32'd2);
                entry.is_resolve   = exp_is_resolve_i;
                entry.prediction   = exp_prediction_i;
                entry.next_pc      = exp_next_pc_i;
                entry.mispredicted = exp_mispredicted_i;
                expect_q.push_back(entry);
            end
            while (expect_q.size() > 0 && expect_q[0].due == cycle) begin
                entry = expect_q.pop_front();
                if (entry.is_resolve) begin
                    resolve_due = 1'b1;
                    compare_word("mispredicted_o", mispredicted_i, entry.mispredicted);
                    // The redirect is only visible while the pulse is high
                    if (entry.mispredicted) begin
                        compare_word("next_pc_o", next_pc_i, entry.next_pc);
                    end
                end else begin
                    compare_word("prediction_o.pc", prediction_i.pc, entry.prediction.pc);
                    compare_word("prediction_o.hit", prediction_i.hit, entry.prediction.hit);
                    compare_word("prediction_o.taken", prediction_i.taken,
                                 entry.prediction.taken);
                    // Target of a missing line is undefined
                    if (entry.prediction.hit) begin
                        compare_word("prediction_o.target", prediction_i.target,
                                     entry.prediction.target);
                    end
                    compare_word("next_pc_o", next_pc_i, entry.next_pc);
                end
            end
            if (mispredicted_i && !resolve_due) begin
                $display("mispredicted_o high in cycle %0d, checker saw no expected record",
                         cycle);
                other_errors_o++;
            end
            pending_o = expect_q.size();
        end
    end

endmodule : tb_checker

// ==== test/tb_clock_gen.sv ====
// --------------------------------------------------------------------------
// Clock and reset source for the testbench with a 10 ns period
// Reset is synchronous to the DUT and held high for the first two edges
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        reset_o <= 1'b0;
    end

    always #5 clk_o = ~clk_o;

endmodule : tb_clock_gen
